// File: sim.f
+incdir+source
source/cache_types_pkg.sv
source/tq_pkg.sv
source/tq_entry_ctrl.sv
source/tq_merge_buffer.sv
source/tq_pipe_port.sv
source/cache_tq_top.sv
bench/tb_cache_tq.sv

// File: run_sim.sh
#!/bin/sh
# build and run the transaction queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_cache_tq -o tb_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// File: bench/tb_cache_tq.sv
// testbench of the cache transaction queue: pipe and far-memory models, directed traffic, checks
`timescale 1ns/10ps
`include "tq_defines.svh"

module tb_cache_tq
    import cache_types_pkg::*;
    import tq_pkg::*;
;

localparam int FM_DELAY  = 8;       // far-memory latency after a miss verdict, in cycles
localparam int MAX_CYCLE = 2000;    // tests need under 200 cycles, wide margin

logic clk;
logic rst_n;
logic core_req_valid;
t_core_op core_req_opcode;
t_address core_req_address;
t_word core_req_data;
t_reg_id core_req_reg_id;
logic stall;
logic core_rsp_valid;
t_word core_rsp_data;
t_address core_rsp_address;
t_reg_id core_rsp_reg_id;
logic fm_rsp_valid;
t_tq_id fm_rsp_tq_id;
t_cl fm_rsp_data;
logic lu_req_valid;
t_lu_op lu_req_op;
t_address lu_req_address;
t_cl lu_req_cl_data;
t_word lu_req_data;
t_tq_id lu_req_tq_id;
logic lu_req_rd_ind;
logic lu_req_wr_ind;
t_reg_id lu_req_reg_id;
logic lu_req_mb_hit;
logic lu_rsp_valid;
t_lu_op lu_rsp_op;
t_lu_result lu_rsp_result;
t_tq_id lu_rsp_tq_id;
t_address lu_rsp_address;
t_cl lu_rsp_cl_data;
logic lu_rsp_rd_ind;
t_reg_id lu_rsp_reg_id;

// bench view of the queue
logic [`TQ_NUM_ENTRY-1:0] busy   = '0;
logic [`TQ_NUM_ENTRY-1:0] ready  = '0;   // far-memory line arrived
logic [`TQ_NUM_ENTRY-1:0] parked = '0;   // miss verdict seen
t_word_mask   exp_mask  [`TQ_NUM_ENTRY];
t_cl          exp_wline [`TQ_NUM_ENTRY];  // core-written words
t_cl          fm_line   [`TQ_NUM_ENTRY];
logic         exp_rd    [`TQ_NUM_ENTRY];
logic         exp_wr    [`TQ_NUM_ENTRY];
t_address     exp_addr  [`TQ_NUM_ENTRY];  // address of the waiting read
t_reg_id      exp_reg   [`TQ_NUM_ENTRY];
logic [56:0]  exp_q [$];                  // {address, reg_id, data} of coming core responses
int           rsp_count = 0;
int           cycles = 0;
t_cl_address  hit_cl;                     // the one line the pipe hits on
t_cl          hit_line;
// pipe delay line, index 0 is one cycle old
logic   p_vld [2];
t_lu_op p_op [2];
t_address p_addr [2];
t_cl    p_line [2];
t_tq_id p_id [2];
logic   p_rd [2];
t_reg_id p_reg [2];
int     fm_cnt [`TQ_NUM_ENTRY];
bit     fm_fire = 0;
t_tq_id fm_fire_id;

cache_tq_top dut0 (.*);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// ==================================================
// failure reporting
// ==================================================
task automatic fail_msg(input string what);
    $display("error: %s at time %0t", what, $time);
    $display("Done: errors found");
    $fatal(1);
endtask

task automatic fail_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    $display("error t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    $display("Done: errors found");
    $fatal(1);
endtask

task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (exp === act) else fail_value(name, exp, act);
endtask

// core words under the mask, far-memory words elsewhere
function automatic t_cl merged_line(input int id);
    t_cl line;
    for (int w = 0; w < `TQ_WORDS_IN_CL; w++) begin
        line[w*`TQ_WORD_W +: `TQ_WORD_W] = exp_mask[id][w] ?
            exp_wline[id][w*`TQ_WORD_W +: `TQ_WORD_W] : fm_line[id][w*`TQ_WORD_W +: `TQ_WORD_W];
    end
    return line;
endfunction

function automatic t_address miss_addr(input int idx, input int k);
    return {1'b0, 4'(idx), 11'($urandom), 2'(k), 2'b00};   // top bit clear, never the hit line
endfunction

// record a core request into the bench view of entry id
task automatic merge_into(input int id);
    t_word_offset ofs;
    ofs = core_req_address[3:2];
    if (core_req_opcode == WR_OP) begin
        exp_mask[id][ofs] = 1'b1;
        exp_wline[id][ofs*`TQ_WORD_W +: `TQ_WORD_W] = core_req_data;
        exp_wr[id] = 1'b1;
    end else begin
        exp_rd[id]   = 1'b1;
        exp_addr[id] = core_req_address;
        exp_reg[id]  = core_req_reg_id;
    end
endtask

// ==================================================
// pipe and far-memory models
// ==================================================
always @(negedge clk) begin
    p_vld[1] = p_vld[0];
    p_op[1] = p_op[0];
    p_addr[1] = p_addr[0];
    p_line[1] = p_line[0];
    p_id[1] = p_id[0];
    p_rd[1] = p_rd[0];
    p_reg[1] = p_reg[0];
    p_vld[0] = rst_n && lu_req_valid && !lu_req_mb_hit;   // merged requests get no answer
    p_op[0] = lu_req_op;
    p_addr[0] = lu_req_address;
    p_line[0] = lu_req_cl_data;
    p_id[0] = lu_req_tq_id;
    p_rd[0] = lu_req_rd_ind;
    p_reg[0] = lu_req_reg_id;
end

initial begin
    p_vld[0] = 1'b0;
    p_vld[1] = 1'b0;
    lu_rsp_valid = 1'b0;
    lu_rsp_op = NO_LU;
    lu_rsp_result = HIT;
    lu_rsp_tq_id = '0;
    lu_rsp_address = '0;
    lu_rsp_cl_data = '0;
    lu_rsp_rd_ind = 1'b0;
    lu_rsp_reg_id = '0;
    forever begin
        @(posedge clk);
        #1;
        lu_rsp_valid = p_vld[1];                      // two cycles after the lookup
        lu_rsp_op = p_op[1];
        lu_rsp_tq_id = p_id[1];
        lu_rsp_address = p_addr[1];
        lu_rsp_rd_ind = p_rd[1];
        lu_rsp_reg_id = p_reg[1];
        if (p_op[1] == FILL_LU) begin
            lu_rsp_result = FILL;
            lu_rsp_cl_data = p_line[1];               // echo
        end else if (p_addr[1][19:4] == hit_cl) begin
            lu_rsp_result = HIT;
            lu_rsp_cl_data = hit_line;
        end else begin
            lu_rsp_result = MISS;
            lu_rsp_cl_data = '0;
        end
    end
end

// one far-memory answer per cycle, lowest entry first
always @(negedge clk) begin
    fm_fire = 1'b0;
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        if (fm_cnt[i] == 1 && !fm_fire) begin
            fm_fire = 1'b1;
            fm_fire_id = t_tq_id'(i);
            fm_cnt[i] = 0;
        end else if (fm_cnt[i] > 1) begin
            fm_cnt[i]--;
        end
    end
    if (rst_n && lu_rsp_valid && lu_rsp_result == MISS) fm_cnt[lu_rsp_tq_id] = FM_DELAY;
end

initial begin
    t_cl line;
    fm_rsp_valid = 1'b0;
    fm_rsp_tq_id = '0;
    fm_rsp_data = '0;
    forever begin
        @(posedge clk);
        #1;
        fm_rsp_valid = fm_fire;
        if (fm_fire) begin
            line = {$urandom, $urandom, $urandom, $urandom};
            fm_rsp_tq_id = fm_fire_id;
            fm_rsp_data = line;
            fm_line[fm_fire_id] = line;               // kept for the fill check
        end
    end
end

// ==================================================
// checks, all at the falling edge where outputs are settled
// ==================================================
assert property (@(negedge clk) disable iff (!rst_n)
    (core_req_valid && !stall) |-> (lu_req_op != FILL_LU))
    else fail_msg("fill lookup issued in a cycle with an accepted core request");

assert property (@(negedge clk) disable iff (!rst_n)
    (stall && lu_req_valid) |-> (lu_req_op == FILL_LU))
    else fail_msg("core request looked up while stall is high");

always @(negedge clk) begin
    int id;
    t_cl exp_cl;
    logic [56:0] exp_rsp;
    if (!rst_n) begin
        check_val("stall", 0, stall);                 // idle outputs in reset
        check_val("lu_req_valid", 0, lu_req_valid);
        check_val("core_rsp_valid", 0, core_rsp_valid);
    end else begin
        check_val("stall", &busy, stall);
        if (|ready && !(core_req_valid && !stall)) begin
            assert (lu_req_valid && lu_req_op == FILL_LU)
                else fail_msg("pending fill lookup not issued in a free port cycle");
        end
        if (lu_req_valid) begin
            id = int'(lu_req_tq_id);
            if (lu_req_op == FILL_LU) begin
                assert (ready[id]) else fail_msg("fill lookup for an entry without a fill");
                exp_cl = merged_line(id);
                check_val("lu_req_cl_data", exp_cl, lu_req_cl_data);
                check_val("lu_req_rd_ind", exp_rd[id], lu_req_rd_ind);
                check_val("lu_req_wr_ind", exp_wr[id], lu_req_wr_ind);
                if (exp_rd[id]) exp_q.push_back({exp_addr[id], exp_reg[id],
                    exp_cl[exp_addr[id][3:2]*`TQ_WORD_W +: `TQ_WORD_W]});
                busy[id] = 1'b0;                      // idle from next cycle
                ready[id] = 1'b0;
                parked[id] = 1'b0;
            end else if (lu_req_mb_hit) begin
                assert (busy[id]) else fail_msg("merge hit on an idle entry");
                merge_into(id);
            end else begin
                assert (!busy[id]) else fail_msg("allocation of a busy entry");
                busy[id] = 1'b1;
                exp_mask[id] = '0;
                exp_rd[id] = 1'b0;
                exp_wr[id] = 1'b0;
                merge_into(id);
            end
        end
        if (lu_rsp_valid && lu_rsp_result == HIT) busy[lu_rsp_tq_id] = 1'b0;
        if (lu_rsp_valid && lu_rsp_result == MISS) parked[lu_rsp_tq_id] = 1'b1;
        if (fm_rsp_valid) ready[fm_rsp_tq_id] = 1'b1;
        if (core_rsp_valid) begin
            assert (exp_q.size() > 0) else fail_msg("core response with none expected");
            exp_rsp = exp_q.pop_front();
            check_val("core_rsp_data", exp_rsp[31:0], core_rsp_data);
            check_val("core_rsp_reg_id", exp_rsp[36:32], core_rsp_reg_id);
            check_val("core_rsp_address", exp_rsp[56:37], core_rsp_address);
            rsp_count++;
        end
    end
end

always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLE) fail_msg("timeout, traffic did not drain");
end

// ==================================================
// stimulus
// ==================================================
task automatic send_req(input t_core_op op, input t_address addr, input t_word data,
                        input t_reg_id reg_id, input logic exp_mb,
                        output t_tq_id id, output int stalled);
    stalled = 0;
    @(posedge clk);
    #1;
    core_req_valid = 1'b1;
    core_req_opcode = op;
    core_req_address = addr;
    core_req_data = data;
    core_req_reg_id = reg_id;
    @(negedge clk);
    while (stall) begin                               // core holds the request
        stalled++;
        @(negedge clk);
    end
    check_val("lu_req_valid", 1, lu_req_valid);
    check_val("lu_req_op", (op == WR_OP) ? WR_LU : RD_LU, lu_req_op);
    check_val("lu_req_address", addr, lu_req_address);
    check_val("lu_req_mb_hit", exp_mb, lu_req_mb_hit);
    check_val("lu_req_rd_ind", op == RD_OP, lu_req_rd_ind);
    check_val("lu_req_wr_ind", op == WR_OP, lu_req_wr_ind);
    check_val("lu_req_reg_id", reg_id, lu_req_reg_id);
    if (op == WR_OP) check_val("lu_req_data", data, lu_req_data);   // write word rides along
    id = lu_req_tq_id;
    @(posedge clk);
    #1;
    core_req_valid = 1'b0;
endtask

task automatic wait_drain();
    while (exp_q.size() != 0 || busy != '0) @(posedge clk);
endtask

initial begin
    t_tq_id id0;
    t_tq_id id1;
    int st;
    int k;
    t_address a;
    t_reg_id r;
    void'($urandom(32'h365f));
    rst_n = 1'b0;
    core_req_valid = 1'b0;
    core_req_opcode = RD_OP;
    core_req_address = '0;
    core_req_data = '0;
    core_req_reg_id = '0;
    hit_cl = {1'b1, 15'($urandom)};
    hit_line = {$urandom, $urandom, $urandom, $urandom};
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // read hit returns the addressed word
    k = $urandom % 4;
    r = 5'($urandom);
    a = {hit_cl, 2'(k), 2'b00};
    send_req(RD_OP, a, '0, r, 1'b0, id0, st);
    exp_q.push_back({a, r, hit_line[k*`TQ_WORD_W +: `TQ_WORD_W]});
    wait_drain();

    // write miss, then fill merge
    a = miss_addr(1, $urandom % 4);
    send_req(WR_OP, a, $urandom, '0, 1'b0, id0, st);
    wait_drain();

    // two writes to one line share an entry
    k = $urandom % 4;
    a = miss_addr(2, k);
    send_req(WR_OP, a, $urandom, '0, 1'b0, id0, st);
    send_req(WR_OP, {a[19:4], 2'(k + 1), 2'b00}, $urandom, '0, 1'b1, id1, st);
    check_val("lu_req_tq_id", id0, id1);
    wait_drain();

    // read to a parked line is answered by the fill lookup
    a = miss_addr(3, $urandom % 4);
    send_req(WR_OP, a, $urandom, '0, 1'b0, id0, st);
    while (!parked[id0]) @(posedge clk);
    r = 5'($urandom);
    send_req(RD_OP, {a[19:4], 2'($urandom), 2'b00}, '0, r, 1'b1, id1, st);
    check_val("lu_req_tq_id", id0, id1);
    wait_drain();
    check_val("rsp_count", 2, rsp_count);

    // ==================================================
    // four misses fill the queue, the fifth waits
    // ==================================================
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        send_req(WR_OP, miss_addr(4 + i, $urandom % 4), $urandom, '0, 1'b0, id0, st);
    end
    send_req(WR_OP, miss_addr(9, $urandom % 4), $urandom, '0, 1'b0, id0, st);
    assert (st > 0) else fail_msg("stall never rose with all entries busy");
    wait_drain();

    // write stream to one parked line, the last write lands on its fill-ready cycle
    a = miss_addr(10, $urandom % 4);
    send_req(WR_OP, a, $urandom, '0, 1'b0, id0, st);
    do begin
        send_req(WR_OP, {a[19:4], 2'($urandom), 2'b00}, $urandom, '0, 1'b1, id1, st);
    end while (!ready[id0]);
    wait_drain();

    $display("Done: no errors");
    $finish;
end

endmodule

// File: source/cache_tq_top.sv
// top of the data cache transaction queue, between the core, the lookup pipe and far memory
`timescale 1ns/10ps
`include "tq_defines.svh"

module cache_tq_top
    import cache_types_pkg::*;
    import tq_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // core request, held by the core while stall is high
    input  logic       core_req_valid,
    input  t_core_op   core_req_opcode,
    input  t_address   core_req_address,
    input  t_word      core_req_data,
    input  t_reg_id    core_req_reg_id,
    output logic       stall,
    // core response
    output logic       core_rsp_valid,
    output t_word      core_rsp_data,
    output t_address   core_rsp_address,
    output t_reg_id    core_rsp_reg_id,
    // far memory fill
    input  logic       fm_rsp_valid,
    input  t_tq_id     fm_rsp_tq_id,
    input  t_cl        fm_rsp_data,
    // pipe lookup request
    output logic       lu_req_valid,
    output t_lu_op     lu_req_op,
    output t_address   lu_req_address,
    output t_cl        lu_req_cl_data,
    output t_word      lu_req_data,
    output t_tq_id     lu_req_tq_id,
    output logic       lu_req_rd_ind,
    output logic       lu_req_wr_ind,
    output t_reg_id    lu_req_reg_id,
    output logic       lu_req_mb_hit,
    // pipe lookup response
    input  logic       lu_rsp_valid,
    input  t_lu_op     lu_rsp_op,
    input  t_lu_result lu_rsp_result,
    input  t_tq_id     lu_rsp_tq_id,
    input  t_address   lu_rsp_address,
    input  t_cl        lu_rsp_cl_data,
    input  logic       lu_rsp_rd_ind,
    input  t_reg_id    lu_rsp_reg_id
);

// entry controller to port arbiter
logic         core_take;
t_tq_id       core_tq_id;
logic         core_mb_hit;
logic         fill_ready;
t_tq_id       fill_tq_id;
t_address     fill_address;
logic         fill_rd_ind;
logic         fill_wr_ind;
t_reg_id      fill_reg_id;
logic         fill_grant;                     // back from the arbiter
t_cl          fill_line;                      // merge buffer read port
// entry controller to merge buffer
logic         mb_alloc;
logic         mb_wr_merge;
logic [`TQ_NUM_ENTRY-1:0] mb_fill_merge;
t_tq_id       mb_entry;
t_word_offset mb_word_offset;

// wires above carry the same names as the sub-block ports
tq_entry_ctrl   u_entry_ctrl   (.*);
tq_merge_buffer u_merge_buffer (.*);
tq_pipe_port    u_pipe_port    (.*);

endmodule

// File: source/tq_pipe_port.sv
// lookup port arbiter of the transaction queue and decoder of pipe responses into core responses
`timescale 1ns/10ps

module tq_pipe_port
    import cache_types_pkg::*;
    import tq_pkg::*;
(
    // core lookup source
    input  t_core_op   core_req_opcode,
    input  t_address   core_req_address,
    input  t_word      core_req_data,
    input  t_reg_id    core_req_reg_id,
    input  logic       core_take,
    input  t_tq_id     core_tq_id,
    input  logic       core_mb_hit,
    // fill lookup source
    input  logic       fill_ready,
    input  t_tq_id     fill_tq_id,
    input  t_address   fill_address,
    input  logic       fill_rd_ind,
    input  logic       fill_wr_ind,
    input  t_reg_id    fill_reg_id,
    input  t_cl        fill_line,
    // pipe response
    input  logic       lu_rsp_valid,
    input  t_lu_op     lu_rsp_op,
    input  t_lu_result lu_rsp_result,
    input  t_address   lu_rsp_address,
    input  t_cl        lu_rsp_cl_data,
    input  logic       lu_rsp_rd_ind,
    input  t_reg_id    lu_rsp_reg_id,
    output logic       fill_grant,
    // pipe lookup request
    output logic       lu_req_valid,
    output t_lu_op     lu_req_op,
    output t_address   lu_req_address,
    output t_cl        lu_req_cl_data,
    output t_word      lu_req_data,
    output t_tq_id     lu_req_tq_id,
    output logic       lu_req_rd_ind,
    output logic       lu_req_wr_ind,
    output t_reg_id    lu_req_reg_id,
    output logic       lu_req_mb_hit,
    // core response
    output logic       core_rsp_valid,
    output t_word      core_rsp_data,
    output t_address   core_rsp_address,
    output t_reg_id    core_rsp_reg_id
);

logic rd_hit;
logic fill_rd;

// ==================================================
// lookup port, core first
// ==================================================
assign fill_grant = fill_ready && !core_take;   // fill only rides idle core cycles

always_comb begin
    lu_req_valid   = 1'b0;
    lu_req_op      = NO_LU;
    lu_req_address = '0;
    lu_req_cl_data = '0;
    lu_req_data    = '0;
    lu_req_tq_id   = '0;
    lu_req_rd_ind  = 1'b0;
    lu_req_wr_ind  = 1'b0;
    lu_req_reg_id  = '0;
    lu_req_mb_hit  = 1'b0;
    if (core_take) begin
        lu_req_valid   = 1'b1;
        lu_req_op      = (core_req_opcode == WR_OP) ? WR_LU : RD_LU;
        lu_req_address = core_req_address;
        lu_req_data    = core_req_data;
        lu_req_tq_id   = core_tq_id;
        lu_req_rd_ind  = (core_req_opcode == RD_OP);
        lu_req_wr_ind  = (core_req_opcode == WR_OP);
        lu_req_reg_id  = core_req_reg_id;
        lu_req_mb_hit  = core_mb_hit;           // pipe drops it, entry already holds the line
    end else if (fill_ready) begin
        lu_req_valid   = 1'b1;
        lu_req_op      = FILL_LU;
        lu_req_address = fill_address;
        lu_req_cl_data = fill_line;
        lu_req_tq_id   = fill_tq_id;
        lu_req_rd_ind  = fill_rd_ind;
        lu_req_wr_ind  = fill_wr_ind;
        lu_req_reg_id  = fill_reg_id;
    end
end

// ==================================================
// core response
// ==================================================
assign rd_hit  = lu_rsp_valid && (lu_rsp_op == RD_LU) && (lu_rsp_result == HIT);
assign fill_rd = lu_rsp_valid && (lu_rsp_op == FILL_LU) && lu_rsp_rd_ind;  // parked read

assign core_rsp_valid   = rd_hit || fill_rd;
assign core_rsp_data    = cl_word(lu_rsp_cl_data, addr_word(lu_rsp_address));
assign core_rsp_address = lu_rsp_address;
assign core_rsp_reg_id  = lu_rsp_reg_id;

endmodule

// File: source/tq_merge_buffer.sv
// per-entry line storage of the transaction queue, merging core writes and far-memory fills
`timescale 1ns/10ps
`include "tq_defines.svh"

module tq_merge_buffer
    import cache_types_pkg::*;
    import tq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mb_alloc,        // clear the entry
    input  logic                     mb_wr_merge,     // write one core word
    input  logic [`TQ_NUM_ENTRY-1:0] mb_fill_merge,   // take the far-memory line
    input  t_tq_id                   mb_entry,
    input  t_word_offset             mb_word_offset,
    input  t_word                    core_req_data,
    input  t_cl                      fm_rsp_data,
    input  t_tq_id                   fill_tq_id,
    output t_cl                      fill_line
);

t_cl        line_q [`TQ_NUM_ENTRY];
t_cl        line_d [`TQ_NUM_ENTRY];
t_word_mask mask_q [`TQ_NUM_ENTRY];     // words written by the core
t_word_mask mask_d [`TQ_NUM_ENTRY];

// ==================================================
// merge
// ==================================================
always_comb begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        line_d[i] = line_q[i];
        mask_d[i] = mask_q[i];
        if (mb_alloc && (mb_entry == t_tq_id'(i))) begin
            line_d[i] = '0;
            mask_d[i] = '0;
        end
        for (int w = 0; w < `TQ_WORDS_IN_CL; w++) begin
            if (mb_wr_merge && (mb_entry == t_tq_id'(i)) &&
                (mb_word_offset == t_word_offset'(w))) begin
                // core word wins, also over a fill in the same cycle
                line_d[i][w*`TQ_WORD_W +: `TQ_WORD_W] = core_req_data;
                mask_d[i][w] = 1'b1;
            end else if (mb_fill_merge[i] && !mask_q[i][w]) begin
                line_d[i][w*`TQ_WORD_W +: `TQ_WORD_W] = fm_rsp_data[w*`TQ_WORD_W +: `TQ_WORD_W];
            end
        end
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        if (!rst_n) begin
            mask_q[i] <= '0;
        end else begin
            mask_q[i] <= mask_d[i];
        end
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        line_q[i] <= line_d[i];
    end
end

assign fill_line = line_q[fill_tq_id];   // line for the pending fill lookup

endmodule

// File: source/tq_entry_ctrl.sv
// per-entry state machines of the transaction queue: allocation, merge hits, fill pick, stall
`timescale 1ns/10ps
`include "tq_defines.svh"

module tq_entry_ctrl
    import cache_types_pkg::*;
    import tq_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    // core request
    input  logic                     core_req_valid,
    input  t_core_op                 core_req_opcode,
    input  t_address                 core_req_address,
    input  t_reg_id                  core_req_reg_id,
    // far memory and pipe responses
    input  logic                     fm_rsp_valid,
    input  t_tq_id                   fm_rsp_tq_id,
    input  logic                     lu_rsp_valid,
    input  t_lu_result               lu_rsp_result,
    input  t_tq_id                   lu_rsp_tq_id,
    input  logic                     fill_grant,      // port carries the fill lookup
    output logic                     stall,
    // core lookup source
    output logic                     core_take,
    output t_tq_id                   core_tq_id,
    output logic                     core_mb_hit,
    // fill lookup source
    output logic                     fill_ready,
    output t_tq_id                   fill_tq_id,
    output t_address                 fill_address,
    output logic                     fill_rd_ind,
    output logic                     fill_wr_ind,
    output t_reg_id                  fill_reg_id,
    // merge buffer control
    output logic                     mb_alloc,
    output logic                     mb_wr_merge,
    output logic [`TQ_NUM_ENTRY-1:0] mb_fill_merge,   // one bit per entry
    output t_tq_id                   mb_entry,
    output t_word_offset             mb_word_offset
);

t_tq_state    state_q    [`TQ_NUM_ENTRY];
t_tq_state    state_d    [`TQ_NUM_ENTRY];
t_cl_address  cl_addr_q  [`TQ_NUM_ENTRY];
t_word_offset word_ofs_q [`TQ_NUM_ENTRY];   // offset of the word to return
t_reg_id      reg_id_q   [`TQ_NUM_ENTRY];
logic [`TQ_NUM_ENTRY-1:0] rd_ind_q;          // a read waits on this entry
logic [`TQ_NUM_ENTRY-1:0] wr_ind_q;          // line holds core writes

logic [`TQ_NUM_ENTRY-1:0] free_vec;
logic [`TQ_NUM_ENTRY-1:0] ready_vec;
logic [`TQ_NUM_ENTRY-1:0] hit_vec;
t_tq_id       free_id;
t_tq_id       hit_id;
logic         any_hit;
logic         alloc;
logic         merge;
t_cl_address  req_cl;

assign req_cl = addr_cl(core_req_address);

// ==================================================
// entry scan
// ==================================================
always_comb begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        free_vec[i]  = (state_q[i] == S_IDLE);
        ready_vec[i] = (state_q[i] == S_MB_FILL_READY);
        // parked lines take reads and writes, an in-flight lookup only writes
        hit_vec[i]   = core_req_valid && !rd_ind_q[i] && (cl_addr_q[i] == req_cl) &&
                       ((state_q[i] == S_MB_WAIT_FILL) || (state_q[i] == S_MB_FILL_READY) ||
                        ((state_q[i] == S_LU_CORE) && (core_req_opcode == WR_OP)));
        mb_fill_merge[i] = fm_rsp_valid && (fm_rsp_tq_id == t_tq_id'(i)) &&
                           (state_q[i] == S_MB_WAIT_FILL);
    end
end

assign free_id   = first_one(free_vec);
assign hit_id    = first_one(hit_vec);
assign any_hit   = |hit_vec;
assign stall     = ~|free_vec;                  // no idle entry left
assign core_take = core_req_valid && !stall;
assign alloc     = core_take && !any_hit;
assign merge     = core_take && any_hit;

assign core_tq_id  = any_hit ? hit_id : free_id;
assign core_mb_hit = any_hit;

// lowest fill-ready entry goes next
assign fill_ready   = |ready_vec;
assign fill_tq_id   = first_one(ready_vec);
assign fill_address = {cl_addr_q[fill_tq_id], word_ofs_q[fill_tq_id], {`TQ_BYTE_OFS_W{1'b0}}};
assign fill_rd_ind  = rd_ind_q[fill_tq_id];
assign fill_wr_ind  = wr_ind_q[fill_tq_id];
assign fill_reg_id  = reg_id_q[fill_tq_id];

assign mb_alloc       = alloc;
assign mb_wr_merge    = core_take && (core_req_opcode == WR_OP);  // alloc write or merge write
assign mb_entry       = core_tq_id;
assign mb_word_offset = addr_word(core_req_address);

// ==================================================
// next state
// ==================================================
always_comb begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        state_d[i] = state_q[i];
        case (state_q[i])
            S_IDLE: begin
                if (alloc && (free_id == t_tq_id'(i))) begin
                    state_d[i] = S_LU_CORE;
                end
            end
            S_LU_CORE: begin
                // a FILL result belongs to the previous owner of this id
                if (lu_rsp_valid && (lu_rsp_tq_id == t_tq_id'(i))) begin
                    if (lu_rsp_result == HIT) begin
                        state_d[i] = S_IDLE;
                    end else if (lu_rsp_result == MISS) begin
                        state_d[i] = S_MB_WAIT_FILL;
                    end
                end
            end
            S_MB_WAIT_FILL: begin
                if (mb_fill_merge[i]) begin
                    state_d[i] = S_MB_FILL_READY;
                end
            end
            default: begin                      // S_MB_FILL_READY
                if (fill_grant && (fill_tq_id == t_tq_id'(i))) begin
                    state_d[i] = S_IDLE;
                end
            end
        endcase
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        if (!rst_n) begin
            state_q[i] <= S_IDLE;
        end else begin
            state_q[i] <= state_d[i];
        end
    end
end

// entry fields, loaded on allocation and updated on merges
always_ff @(posedge clk) begin
    for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
        if (alloc && (free_id == t_tq_id'(i))) begin
            cl_addr_q[i]  <= req_cl;
            word_ofs_q[i] <= mb_word_offset;
            reg_id_q[i]   <= core_req_reg_id;
            rd_ind_q[i]   <= (core_req_opcode == RD_OP);
            wr_ind_q[i]   <= (core_req_opcode == WR_OP);
        end else if (merge && (hit_id == t_tq_id'(i))) begin
            if (core_req_opcode == RD_OP) begin
                rd_ind_q[i]   <= 1'b1;              // fill lookup answers this read
                word_ofs_q[i] <= mb_word_offset;
                reg_id_q[i]   <= core_req_reg_id;
            end else begin
                wr_ind_q[i] <= 1'b1;
            end
        end
    end
end

endmodule

// File: source/tq_pkg.sv
// types private to the transaction queue: entry id, entry state and word mask
package tq_pkg;

`include "tq_defines.svh"

typedef logic [$clog2(`TQ_NUM_ENTRY)-1:0] t_tq_id;
typedef logic [`TQ_WORDS_IN_CL-1:0]       t_word_mask;  // one modified bit per word

// entry life cycle
typedef enum logic [1:0] {
    S_IDLE          = 2'd0,   // free
    S_LU_CORE       = 2'd1,   // core lookup in the pipe
    S_MB_WAIT_FILL  = 2'd2,   // missed, waiting for far memory
    S_MB_FILL_READY = 2'd3    // line merged, waiting for the lookup port
} t_tq_state;

// index of the lowest set bit, zero when none is set
function automatic t_tq_id first_one(input logic [`TQ_NUM_ENTRY-1:0] vec);
    t_tq_id idx;
    idx = '0;
    for (int i = `TQ_NUM_ENTRY-1; i >= 0; i--) begin
        if (vec[i]) begin
            idx = t_tq_id'(i);
        end
    end
    return idx;
endfunction

endpackage

// File: source/cache_types_pkg.sv
// cache-wide data, address and opcode types, imported by every block that touches a request
package cache_types_pkg;

`include "tq_defines.svh"

typedef logic [`TQ_WORD_W-1:0]                    t_word;
typedef logic [`TQ_WORD_W*`TQ_WORDS_IN_CL-1:0]    t_cl;        // full line
typedef logic [`TQ_ADDR_W-1:0]                    t_address;   // byte address
typedef logic [`TQ_ADDR_W-`TQ_WORD_OFS_W-`TQ_BYTE_OFS_W-1:0] t_cl_address; // tag + set
typedef logic [`TQ_WORD_OFS_W-1:0]                t_word_offset;
typedef logic [`TQ_REG_ID_W-1:0]                  t_reg_id;

typedef enum logic {
    RD_OP = 1'b0,
    WR_OP = 1'b1
} t_core_op;

// lookup kind on the pipe port
typedef enum logic [1:0] {
    NO_LU   = 2'd0,
    RD_LU   = 2'd1,
    WR_LU   = 2'd2,
    FILL_LU = 2'd3
} t_lu_op;

// pipe verdict
typedef enum logic [1:0] {
    HIT  = 2'd0,
    MISS = 2'd1,
    FILL = 2'd2      // answer to a fill lookup
} t_lu_result;

// line address part of a byte address
function automatic t_cl_address addr_cl(input t_address addr);
    return addr[`TQ_ADDR_W-1:`TQ_WORD_OFS_W+`TQ_BYTE_OFS_W];
endfunction

function automatic t_word_offset addr_word(input t_address addr);
    return addr[`TQ_BYTE_OFS_W +: `TQ_WORD_OFS_W];
endfunction

// word w of a line, word 0 in the low bits
function automatic t_word cl_word(input t_cl line, input t_word_offset w);
    return line[w*`TQ_WORD_W +: `TQ_WORD_W];
endfunction

endpackage

// File: source/tq_defines.svh
// sizing of the cache transaction queue, included by the packages, the RTL and the bench
`ifndef TQ_DEFINES_SVH
`define TQ_DEFINES_SVH

// ==================================================
// queue and line geometry
// ==================================================
`define TQ_NUM_ENTRY    4       // transaction queue entries
`define TQ_WORD_W       32      // core data word
`define TQ_WORDS_IN_CL  4       // words per cache line

// ==================================================
// address fields, msb to lsb: line address, word offset, byte offset
// ==================================================
`define TQ_ADDR_W       20      // byte address
`define TQ_REG_ID_W     5       // core destination register
`define TQ_BYTE_OFS_W   2       // byte within a word
`define TQ_WORD_OFS_W   2       // word within a line

`endif
